// File: hdl/snd_config.svh
`ifndef SND_CONFIG_SVH
`define SND_CONFIG_SVH

// clocks per PSG clock enable
`define SND_CEN_DIV   4

// output level per amplitude step
`define SND_PSG_GAIN  16

// clock enables per tone counter step
`define SND_TONE_PRE  8

// highest ROM address
`define SND_ROM_TOP   16'h2FFF

`endif

// File: hdl/snd_bus_pkg.sv
package snd_bus_pkg;

typedef struct packed {
    logic        awvalid;
    logic [15:0] awaddr;
    logic        wvalid;
    logic [7:0]  wdata;
    logic        wstrb;   // single byte lane
    logic        bready;
    logic        arvalid;
    logic [15:0] araddr;
    logic        rready;
} axil_req_t;

typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
    logic       arready;
    logic       rvalid;
    logic [7:0] rdata;
    logic [1:0] rresp;
} axil_rsp_t;

localparam logic [1:0] RESP_OKAY   = 2'b00;
localparam logic [1:0] RESP_SLVERR = 2'b10;

typedef enum logic [2:0] {
    IDLE,
    ACCESS,
    ROM_WAIT,
    RESP_W,
    RESP_R
} bus_state_e;

typedef enum logic [2:0] {
    REG_ROM,
    REG_IACK,   // old work RAM window
    PSG0_ADDR,
    PSG0_DATA,
    PSG1_ADDR,
    PSG1_DATA,
    REG_FILTER,
    REG_NONE
} region_e;

typedef struct packed {
    logic        stb;
    logic        we;
    region_e     region;
    logic [15:0] addr;
    logic [7:0]  wdata;
} snd_acc_t;

endpackage

// File: hdl/snd_psg_pkg.sv
package snd_psg_pkg;

typedef enum logic [3:0] {
    TONE_A_LO = 4'd0,
    TONE_A_HI = 4'd1,
    TONE_B_LO = 4'd2,
    TONE_B_HI = 4'd3,
    TONE_C_LO = 4'd4,
    TONE_C_HI = 4'd5,
    MIXER     = 4'd7,   // bit n set forces channel n steady
    AMP_A     = 4'd8,
    AMP_B     = 4'd9,
    AMP_C     = 4'd10,
    PORT_A    = 4'd14,
    PORT_B    = 4'd15
} psg_reg_e;

// one channel as seen by the RC filter stage
typedef struct packed {
    logic [7:0] level;
    logic [3:0] rcen;   // one-hot capacitor select
} snd_chan_t;

typedef logic [1:0] filt_code_t;

endpackage

// File: hdl/snd_bus_ctrl.sv
`timescale 1ns/1ps
`include "snd_config.svh"

module snd_bus_ctrl import snd_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  axil_req_t   bus_req,
    output axil_rsp_t   bus_rsp,
    output snd_acc_t    access,
    input  logic [7:0]  psg0_rdata,
    input  logic [7:0]  psg1_rdata,
    output logic [13:0] rom_addr,
    output logic        rom_cs,
    input  logic [7:0]  rom_data,
    input  logic        rom_ok
);

bus_state_e  state;
logic        idle;
logic        rd_hs;
logic        wr_hs;
logic [15:0] req_addr;
region_e     req_region;
logic        acc_we;
logic        acc_strb;
region_e     acc_region;
logic [15:0] acc_addr;
logic [7:0]  acc_wdata;
logic [7:0]  rdata_q;

function automatic region_e decode(input logic [15:0] a);
    region_e r;
    if (a <= `SND_ROM_TOP) begin
        r = REG_ROM;
    end else begin
        case (a[15:12])
            4'h3:    r = REG_IACK;
            4'h4:    r = PSG0_ADDR;
            4'h5:    r = PSG0_DATA;
            4'h6:    r = PSG1_ADDR;
            4'h7:    r = PSG1_DATA;
            default: r = REG_FILTER;  // 0x8000 and up
        endcase
    end
    return r;
endfunction

assign idle       = state == IDLE;
assign rd_hs      = idle && bus_req.arvalid;  // reads take priority
assign wr_hs      = idle && !bus_req.arvalid && bus_req.awvalid && bus_req.wvalid;
assign req_addr   = bus_req.arvalid ? bus_req.araddr : bus_req.awaddr;
assign req_region = decode(req_addr);
assign rom_addr   = acc_addr[13:0];

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        state  <= IDLE;
        rom_cs <= 1'b0;
    end else begin
        case (state)
            IDLE: begin
                if (rd_hs) begin
                    state  <= req_region == REG_ROM ? ROM_WAIT : ACCESS;
                    rom_cs <= req_region == REG_ROM;
                end else if (wr_hs) begin
                    state <= ACCESS;
                end
            end
            ACCESS: state <= acc_we ? RESP_W : RESP_R;
            ROM_WAIT: begin
                if (rom_ok) begin  // latency set by the memory side
                    rom_cs <= 1'b0;
                    state  <= RESP_R;
                end
            end
            RESP_W: if (bus_req.bready) state <= IDLE;
            RESP_R: if (bus_req.rready) state <= IDLE;
            default: state <= IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (rd_hs || wr_hs) begin
        acc_we     <= wr_hs;
        acc_strb   <= bus_req.wstrb;
        acc_region <= req_region;
        acc_addr   <= req_addr;
        acc_wdata  <= bus_req.wdata;
    end
    if (state == ACCESS) begin
        case (acc_region)
            PSG0_DATA: rdata_q <= psg0_rdata;
            PSG1_DATA: rdata_q <= psg1_rdata;
            default:   rdata_q <= 8'hFF;  // open bus
        endcase
    end else if (state == ROM_WAIT && rom_ok) begin
        rdata_q <= rom_data;
    end
end

always_comb begin
    access.stb    = state == ACCESS;
    access.we     = acc_we && acc_strb;  // empty strobe writes nothing
    access.region = acc_region;
    access.addr   = acc_addr;
    access.wdata  = acc_wdata;
end

always_comb begin
    bus_rsp.awready = wr_hs;
    bus_rsp.wready  = wr_hs;
    bus_rsp.bvalid  = state == RESP_W;
    bus_rsp.bresp   = acc_region == REG_ROM ? RESP_SLVERR : RESP_OKAY;
    bus_rsp.arready = rd_hs;
    bus_rsp.rvalid  = state == RESP_R;
    bus_rsp.rdata   = rdata_q;
    bus_rsp.rresp   = RESP_OKAY;
end

a_rom_cs_wait: assert property (@(posedge clk) disable iff (rst)
    rom_cs |-> state == ROM_WAIT);

a_stb_single: assert property (@(posedge clk) disable iff (rst)
    access.stb |=> !access.stb);

a_resp_excl: assert property (@(posedge clk) disable iff (rst)
    !(bus_rsp.bvalid && bus_rsp.rvalid));

endmodule

// File: hdl/snd_timer.sv
`timescale 1ns/1ps
`include "snd_config.svh"

module snd_timer (
    input  logic       clk,
    input  logic       rst,
    output logic       psg_cen,
    output logic [7:0] port_b_word
);

localparam int DIV_W = $clog2(`SND_CEN_DIV);

logic [DIV_W-1:0] div_cnt;
logic [8:0]       cnt;
logic [3:0]       biq;   // bi-quinary tempo counter

assign psg_cen     = div_cnt == DIV_W'(`SND_CEN_DIV - 1);
assign port_b_word = {biq[3:1], cnt[8], 4'd0};

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        div_cnt <= '0;
        cnt     <= '0;
        biq     <= '0;
    end else begin
        div_cnt <= psg_cen ? '0 : div_cnt + 1'b1;
        if (psg_cen) begin
            cnt <= cnt + 1'b1;
            if (&cnt) begin  // wrap of the free counter
                if (biq[2:0] == 3'd4) begin
                    biq <= {~biq[3], 3'd0};
                end else begin
                    biq <= {biq[3], biq[2:0] + 3'd1};
                end
            end
        end
    end
end

a_biq_range: assert property (@(posedge clk) disable iff (rst)
    biq[2:0] <= 3'd4);

endmodule

// File: hdl/snd_psg.sv
`timescale 1ns/1ps
`include "snd_config.svh"

module snd_psg import snd_bus_pkg::*, snd_psg_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cen,
    input  snd_acc_t              access,
    input  region_e               addr_region,
    input  region_e               data_region,
    input  logic [7:0]            port_a,
    input  logic [7:0]            port_b,
    input  filt_code_t [2:0]      filt,
    output logic [7:0]            rdata,
    output snd_chan_t [2:0]       chan
);

localparam int PRE_W = $clog2(`SND_TONE_PRE);

logic [3:0]             addr_q;   // selected register index
logic [2:0][7:0]        tone_lo;
logic [2:0][3:0]        tone_hi;
logic [7:0]             mixer;
logic [2:0][3:0]        amp;
logic [PRE_W-1:0]       pre_cnt;
logic                   tone_step;
logic [2:0][11:0]       tcnt;
logic [2:0]             sq;
logic [2:0][7:0]        level_q;

assign tone_step = cen && pre_cnt == PRE_W'(`SND_TONE_PRE - 1);

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        addr_q  <= '0;
        tone_lo <= '0;
        tone_hi <= '0;
        mixer   <= '0;
        amp     <= '0;
    end else if (access.stb && access.we) begin
        if (access.region == addr_region) begin
            addr_q <= access.wdata[3:0];
        end
        if (access.region == data_region) begin
            case (psg_reg_e'(addr_q))
                TONE_A_LO: tone_lo[0] <= access.wdata;
                TONE_A_HI: tone_hi[0] <= access.wdata[3:0];
                TONE_B_LO: tone_lo[1] <= access.wdata;
                TONE_B_HI: tone_hi[1] <= access.wdata[3:0];
                TONE_C_LO: tone_lo[2] <= access.wdata;
                TONE_C_HI: tone_hi[2] <= access.wdata[3:0];
                MIXER:     mixer      <= access.wdata;
                AMP_A:     amp[0]     <= access.wdata[3:0];
                AMP_B:     amp[1]     <= access.wdata[3:0];
                AMP_C:     amp[2]     <= access.wdata[3:0];
                default:   ;  // ports are input only
            endcase
        end
    end
end

always_comb begin
    case (psg_reg_e'(addr_q))
        TONE_A_LO: rdata = tone_lo[0];
        TONE_A_HI: rdata = {4'd0, tone_hi[0]};
        TONE_B_LO: rdata = tone_lo[1];
        TONE_B_HI: rdata = {4'd0, tone_hi[1]};
        TONE_C_LO: rdata = tone_lo[2];
        TONE_C_HI: rdata = {4'd0, tone_hi[2]};
        MIXER:     rdata = mixer;
        AMP_A:     rdata = {4'd0, amp[0]};
        AMP_B:     rdata = {4'd0, amp[1]};
        AMP_C:     rdata = {4'd0, amp[2]};
        PORT_A:    rdata = port_a;
        PORT_B:    rdata = port_b;
        default:   rdata = 8'd0;
    endcase
end

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        pre_cnt <= '0;
        tcnt    <= '0;
        sq      <= '0;
        level_q <= '0;
    end else if (cen) begin
        pre_cnt <= tone_step ? '0 : pre_cnt + 1'b1;
        for (int i = 0; i < 3; i++) begin
            if (tone_step) begin
                if (tcnt[i] >= {tone_hi[i], tone_lo[i]}) begin  // half period done
                    tcnt[i] <= '0;
                    sq[i]   <= ~sq[i];
                end else begin
                    tcnt[i] <= tcnt[i] + 1'b1;
                end
            end
            // mixer bit set holds the channel at full amplitude
            level_q[i] <= (mixer[i] || sq[i]) ? 8'(amp[i] * `SND_PSG_GAIN) : 8'd0;
        end
    end
end

always_comb begin
    for (int i = 0; i < 3; i++) begin
        chan[i].level = level_q[i];
        chan[i].rcen  = 4'b0001 << filt[i];
    end
end

endmodule

// File: hdl/snd_ctrl_regs.sv
`timescale 1ns/1ps

module snd_ctrl_regs import snd_bus_pkg::*, snd_psg_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  snd_acc_t         access,
    input  logic             snd_on,
    output logic             irq,
    output filt_code_t [2:0] filt0,
    output filt_code_t [2:0] filt1,
    output logic [7:0]       st_dout
);

logic        snd_on_q;
logic        snd_rise;
logic        iack;
logic        filt_ld;
logic [11:0] filt_latch;   // two bits per channel

assign snd_rise = snd_on && !snd_on_q;
assign iack     = access.stb && access.region == REG_IACK;  // read or write
assign filt_ld  = access.stb && access.we && access.region == REG_FILTER;

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        snd_on_q <= 1'b0;
        irq      <= 1'b0;
    end else begin
        snd_on_q <= snd_on;
        if (snd_rise) begin
            irq <= 1'b1;   // set beats ack
        end else if (iack) begin
            irq <= 1'b0;
        end
    end
end

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        filt_latch <= '0;
        filt0      <= '0;
        filt1      <= '0;
        st_dout    <= '0;
    end else begin
        if (filt_ld) filt_latch <= access.addr[11:0];  // data bus unused
        filt1[0] <= filt_latch[1:0];
        filt1[1] <= filt_latch[3:2];
        filt1[2] <= filt_latch[5:4];
        filt0[0] <= filt_latch[7:6];
        filt0[1] <= filt_latch[9:8];
        filt0[2] <= filt_latch[11:10];
        st_dout  <= {2'b00, |filt_latch[11:10], |filt_latch[9:8], |filt_latch[7:6],
                     |filt_latch[5:4], |filt_latch[3:2], |filt_latch[1:0]};
    end
end

endmodule

// File: hdl/snd_board.sv
`timescale 1ns/1ps

module snd_board import snd_bus_pkg::*, snd_psg_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  axil_req_t       bus_req,
    output axil_rsp_t       bus_rsp,
    output logic [13:0]     rom_addr,
    output logic            rom_cs,
    input  logic [7:0]      rom_data,
    input  logic            rom_ok,
    input  logic [7:0]      main_latch,
    input  logic            snd_on,
    output logic            irq,
    output snd_chan_t [2:0] psg0_chan,
    output snd_chan_t [2:0] psg1_chan,
    output logic [7:0]      st_dout
);

snd_acc_t         access;
logic [7:0]       psg0_rdata;
logic [7:0]       psg1_rdata;
logic             psg_cen;
logic [7:0]       port_b_word;
filt_code_t [2:0] filt0;
filt_code_t [2:0] filt1;

snd_bus_ctrl u_bus (
    .clk        ( clk         ),
    .rst        ( rst         ),
    .bus_req    ( bus_req     ),
    .bus_rsp    ( bus_rsp     ),
    .access     ( access      ),
    .psg0_rdata ( psg0_rdata  ),
    .psg1_rdata ( psg1_rdata  ),
    .rom_addr   ( rom_addr    ),
    .rom_cs     ( rom_cs      ),
    .rom_data   ( rom_data    ),
    .rom_ok     ( rom_ok      )
);

snd_timer u_timer (
    .clk         ( clk         ),
    .rst         ( rst         ),
    .psg_cen     ( psg_cen     ),
    .port_b_word ( port_b_word )
);

snd_psg u_psg0 (
    .clk         ( clk         ),
    .rst         ( rst         ),
    .cen         ( psg_cen     ),
    .access      ( access      ),
    .addr_region ( PSG0_ADDR   ),
    .data_region ( PSG0_DATA   ),
    .port_a      ( main_latch  ),  // sound command from the main CPU
    .port_b      ( port_b_word ),
    .filt        ( filt0       ),
    .rdata       ( psg0_rdata  ),
    .chan        ( psg0_chan   )
);

snd_psg u_psg1 (
    .clk         ( clk         ),
    .rst         ( rst         ),
    .cen         ( psg_cen     ),
    .access      ( access      ),
    .addr_region ( PSG1_ADDR   ),
    .data_region ( PSG1_DATA   ),
    .port_a      ( 8'd0        ),
    .port_b      ( 8'd0        ),
    .filt        ( filt1       ),
    .rdata       ( psg1_rdata  ),
    .chan        ( psg1_chan   )
);

snd_ctrl_regs u_ctrl (
    .clk     ( clk     ),
    .rst     ( rst     ),
    .access  ( access  ),
    .snd_on  ( snd_on  ),
    .irq     ( irq     ),
    .filt0   ( filt0   ),
    .filt1   ( filt1   ),
    .st_dout ( st_dout )
);

endmodule

// File: bench/snd_board_tb.sv
`timescale 1ns/1ps
`include "snd_config.svh"

module snd_board_tb import snd_bus_pkg::*, snd_psg_pkg::*; ();

localparam int TIMEOUT_CYCLES = 20000;   // several times the length of all tests
localparam int BIQ_READS      = 400;
localparam int TONE_PER       = 3;
// one full square period plus one tone step of phase slack
localparam int TONE_BOUND     = (2 * (TONE_PER + 1) + 1) * `SND_TONE_PRE * `SND_CEN_DIV;

logic            clk;
logic            rst;
axil_req_t       bus_req;
axil_rsp_t       bus_rsp;
logic [13:0]     rom_addr;
logic            rom_cs;
logic [7:0]      rom_data;
logic            rom_ok;
logic [7:0]      main_latch;
logic            snd_on;
logic            irq;
snd_chan_t [2:0] psg0_chan;
snd_chan_t [2:0] psg1_chan;
logic [7:0]      st_dout;

int          rom_delay = 1;     // cycles until rom_ok for the next read
int          cycle_cnt = 0;
logic [3:0]  amp_exp [2][3];
logic [11:0] filt_pat = '0;

snd_board UUT (
    .clk        ( clk        ),
    .rst        ( rst        ),
    .bus_req    ( bus_req    ),
    .bus_rsp    ( bus_rsp    ),
    .rom_addr   ( rom_addr   ),
    .rom_cs     ( rom_cs     ),
    .rom_data   ( rom_data   ),
    .rom_ok     ( rom_ok     ),
    .main_latch ( main_latch ),
    .snd_on     ( snd_on     ),
    .irq        ( irq        ),
    .psg0_chan  ( psg0_chan  ),
    .psg1_chan  ( psg1_chan  ),
    .st_dout    ( st_dout    )
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

// external ROM returns low address byte xor high address byte
initial begin
    forever begin
        @(negedge clk);
        if (rom_cs) begin
            repeat (rom_delay) @(posedge clk);
            #1;
            rom_data = rom_addr[7:0] ^ {2'b00, rom_addr[13:8]};
            rom_ok   = 1'b1;
            @(posedge clk);
            #1;
            rom_ok = 1'b0;
        end
    end
end

always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
        abort_run($sformatf("timeout, tests still running after %0d cycles", cycle_cnt));
    end
end

task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first failure");
endtask

task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
        abort_run($sformatf("error %s: expected 0x%02h, actual 0x%02h", name, exp, act));
    end
endtask

task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
        abort_run($sformatf("error %s: expected resp %b, actual resp %b", name, exp, act));
    end
endtask

task automatic check_chan(input string name, input snd_chan_t exp, input snd_chan_t act);
    if (act !== exp) begin
        abort_run($sformatf("error %s: expected level %0d rcen %b, actual level %0d rcen %b",
                            name, exp.level, exp.rcen, act.level, act.rcen));
    end
endtask

function automatic snd_chan_t expected_chan(input logic [3:0] amp, input filt_code_t code);
    snd_chan_t c;
    c.level = 8'(amp * `SND_PSG_GAIN);
    c.rcen  = 4'b0001 << code;
    return c;
endfunction

// low three biq bits run 0..4 then clear and flip the top bit
function automatic logic [3:0] biq_next(input logic [3:0] b);
    logic [3:0] n;
    if (b[2:0] == 3'd4) begin
        n = {~b[3], 3'd0};
    end else begin
        n = {b[3], b[2:0] + 3'd1};
    end
    return n;
endfunction

// only biq[3:1] is visible on port B
function automatic bit biq_step_ok(input logic [2:0] prev, input logic [2:0] cur);
    logic [3:0] b;
    logic [3:0] n;
    bit         ok;
    ok = (cur == prev);
    for (int k = 0; k < 2; k++) begin
        b = {prev, k[0]};
        n = biq_next(b);
        if (b[2:0] <= 3'd4 && n[3:1] == cur) begin
            ok = 1'b1;
        end
    end
    return ok;
endfunction

task automatic axil_write(input logic [15:0] addr, input logic [7:0] data,
                          output logic [1:0] resp);
    int hold;
    hold = $urandom_range(0, 3);
    @(posedge clk);
    #1;
    bus_req.awvalid = 1'b1;
    bus_req.awaddr  = addr;
    bus_req.wvalid  = 1'b1;
    bus_req.wdata   = data;
    bus_req.wstrb   = 1'b1;
    @(negedge clk);
    while (!bus_rsp.awready) @(negedge clk);
    if (!bus_rsp.wready) abort_run("wready did not rise together with awready");
    @(posedge clk);
    #1;
    bus_req.awvalid = 1'b0;
    bus_req.wvalid  = 1'b0;
    @(negedge clk);
    while (!bus_rsp.bvalid) @(negedge clk);
    repeat (hold) begin
        @(negedge clk);
        if (!bus_rsp.bvalid) abort_run("bvalid dropped while bready was held low");
    end
    @(posedge clk);
    #1;
    bus_req.bready = 1'b1;
    @(negedge clk);
    resp = bus_rsp.bresp;
    @(posedge clk);
    #1;
    bus_req.bready = 1'b0;
endtask

task automatic axil_read(input logic [15:0] addr, output logic [7:0] data,
                         output logic [1:0] resp);
    int hold;
    hold      = $urandom_range(0, 3);
    rom_delay = $urandom_range(1, 6);
    @(posedge clk);
    #1;
    bus_req.arvalid = 1'b1;
    bus_req.araddr  = addr;
    @(negedge clk);
    while (!bus_rsp.arready) @(negedge clk);
    @(posedge clk);
    #1;
    bus_req.arvalid = 1'b0;
    @(negedge clk);
    while (!bus_rsp.rvalid) @(negedge clk);
    repeat (hold) begin
        @(negedge clk);
        if (!bus_rsp.rvalid) abort_run("rvalid dropped while rready was held low");
    end
    @(posedge clk);
    #1;
    bus_req.rready = 1'b1;
    @(negedge clk);
    data = bus_rsp.rdata;
    resp = bus_rsp.rresp;
    @(posedge clk);
    #1;
    bus_req.rready = 1'b0;
endtask

task automatic psg_write(input int p, input logic [3:0] idx, input logic [7:0] data);
    logic [1:0] r;
    axil_write(p ? 16'h6000 : 16'h4000, {4'd0, idx}, r);
    check_resp("psg select", RESP_OKAY, r);
    axil_write(p ? 16'h7000 : 16'h5000, data, r);
    check_resp("psg write", RESP_OKAY, r);
endtask

task automatic psg_read(input int p, input logic [3:0] idx, output logic [7:0] data);
    logic [1:0] r;
    axil_write(p ? 16'h6000 : 16'h4000, {4'd0, idx}, r);
    check_resp("psg select", RESP_OKAY, r);
    axil_read(p ? 16'h7000 : 16'h5000, data, r);
    check_resp("psg read", RESP_OKAY, r);
endtask

task automatic check_levels(input string name);
    for (int c = 0; c < 3; c++) begin
        check_chan(name, expected_chan(amp_exp[0][c], filt_pat[6 + 2 * c +: 2]), psg0_chan[c]);
        check_chan(name, expected_chan(amp_exp[1][c], filt_pat[2 * c +: 2]), psg1_chan[c]);
    end
endtask

function automatic logic [7:0] fill_value(input int p, input logic [3:0] idx);
    return 8'h3C ^ {idx, idx} ^ (p ? 8'hA5 : 8'h00);
endfunction

// tone high bytes and amplitudes hold four bits
function automatic logic [7:0] reg_mask(input logic [3:0] idx);
    case (psg_reg_e'(idx))
        TONE_A_HI, TONE_B_HI, TONE_C_HI, AMP_A, AMP_B, AMP_C: return 8'h0F;
        default: return 8'hFF;
    endcase
endfunction

task automatic reset_outputs();
    @(negedge clk);
    check_byte("reset outputs", 8'h00,
               {1'b0, bus_rsp.awready, bus_rsp.wready, bus_rsp.arready,
                bus_rsp.bvalid, bus_rsp.rvalid, rom_cs, irq});
endtask

task automatic rom_reads();
    logic [15:0] addrs [5];
    logic [7:0]  d;
    logic [1:0]  r;
    addrs = '{16'h0000, 16'h0123, 16'h1A5C, 16'h2E81, 16'h2FFF};
    foreach (addrs[i]) begin
        axil_read(addrs[i], d, r);
        check_resp($sformatf("rom read %h", addrs[i]), RESP_OKAY, r);
        check_byte($sformatf("rom read %h", addrs[i]), addrs[i][7:0] ^ addrs[i][15:8], d);
    end
    axil_write(16'h0100, 8'h33, r);
    check_resp("rom write", RESP_SLVERR, r);
    axil_read(16'h8000, d, r);
    check_resp("unmapped read", RESP_OKAY, r);
    check_byte("unmapped read", 8'hFF, d);
endtask

task automatic psg_round_trip();
    logic [3:0] regs [10];
    logic [7:0] d;
    regs = '{4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd7, 4'd8, 4'd9, 4'd10};
    for (int p = 0; p < 2; p++) begin
        foreach (regs[i]) begin
            psg_write(p, regs[i], fill_value(p, regs[i]));
        end
    end
    for (int p = 0; p < 2; p++) begin
        foreach (regs[i]) begin
            psg_read(p, regs[i], d);
            check_byte($sformatf("psg%0d reg %0d", p, regs[i]),
                       fill_value(p, regs[i]) & reg_mask(regs[i]), d);
        end
    end
    psg_read(0, PORT_A, d);
    check_byte("psg0 port A", main_latch, d);
    psg_read(1, PORT_A, d);
    check_byte("psg1 port A", 8'h00, d);
    psg_read(1, PORT_B, d);
    check_byte("psg1 port B", 8'h00, d);
endtask

task automatic channel_levels();
    logic [7:0] lvl;
    bit         seen_lo;
    bit         seen_hi;
    for (int p = 0; p < 2; p++) begin
        psg_write(p, MIXER, 8'h07);   // all three channels steady
        for (int c = 0; c < 3; c++) begin
            psg_write(p, 4'(AMP_A + c), 8'h00);
            amp_exp[p][c] = 4'd0;
        end
    end
    for (int a = 0; a < 16; a++) begin
        for (int p = 0; p < 2; p++) begin
            psg_write(p, 4'(AMP_A + a % 3), 8'(a));
            amp_exp[p][a % 3] = 4'(a);
        end
        repeat (2 * `SND_CEN_DIV) @(posedge clk);
        @(negedge clk);
        check_levels($sformatf("steady level %0d", a));
    end
    psg_write(0, TONE_A_LO, 8'(TONE_PER));
    psg_write(0, TONE_A_HI, 8'h00);
    psg_write(0, AMP_A, 8'd10);
    psg_write(0, MIXER, 8'h06);   // square wave on channel A
    seen_lo = 1'b0;
    seen_hi = 1'b0;
    repeat (TONE_BOUND) begin
        @(negedge clk);
        lvl = psg0_chan[0].level;
        if (lvl == 8'd0) begin
            seen_lo = 1'b1;
        end else begin
            check_byte("tone level", 8'(10 * `SND_PSG_GAIN), lvl);
            seen_hi = 1'b1;
        end
    end
    if (!(seen_lo && seen_hi)) begin
        abort_run("tone channel did not toggle within one period");
    end
    psg_write(0, MIXER, 8'h07);
    amp_exp[0][0] = 4'd10;
    repeat (2 * `SND_CEN_DIV) @(posedge clk);
    @(negedge clk);
    check_levels("steady after tone");
endtask

task automatic filter_select();
    logic [11:0] pats [3];
    logic [7:0]  st;
    logic [1:0]  r;
    pats = '{12'hE4B, 12'h1B6, 12'h000};
    foreach (pats[i]) begin
        axil_write({4'h8, pats[i]}, 8'hA5, r);  // data byte is ignored
        check_resp("filter write", RESP_OKAY, r);
        filt_pat = pats[i];
        st       = 8'h00;
        for (int k = 0; k < 6; k++) begin
            st[k] = pats[i][2 * k] | pats[i][2 * k + 1];
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_levels($sformatf("filter %h", pats[i]));
        check_byte($sformatf("status %h", pats[i]), st, st_dout);
    end
endtask

task automatic irq_handshake();
    logic [7:0] d;
    logic [1:0] r;
    @(negedge clk);
    check_byte("irq idle", 8'd0, {7'd0, irq});
    @(posedge clk);
    #1;
    snd_on = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_byte("irq set", 8'd1, {7'd0, irq});
    axil_read(16'h3000, d, r);
    check_resp("iack read", RESP_OKAY, r);
    check_byte("iack read", 8'hFF, d);
    @(negedge clk);
    check_byte("irq cleared", 8'd0, {7'd0, irq});
    axil_write(16'h3000, 8'h00, r);   // snd_on still high so no new edge
    check_resp("iack write", RESP_OKAY, r);
    @(negedge clk);
    check_byte("irq stays low", 8'd0, {7'd0, irq});
    @(posedge clk);
    #1;
    snd_on = 1'b0;
endtask

task automatic timer_polling();
    logic [7:0] d;
    logic [1:0] r;
    logic [2:0] prev;
    axil_write(16'h4000, 8'(PORT_B), r);
    check_resp("port B select", RESP_OKAY, r);
    axil_read(16'h5000, d, r);
    prev = d[7:5];
    for (int k = 0; k < BIQ_READS; k++) begin
        axil_read(16'h5000, d, r);
        check_resp("port B read", RESP_OKAY, r);
        check_byte("port B low bits", 8'h00, d & 8'h07);
        if (!biq_step_ok(prev, d[7:5])) begin
            abort_run($sformatf("bi-quinary counter jumped from %0d to %0d", prev, d[7:5]));
        end
        prev = d[7:5];
    end
endtask

initial begin
    void'($urandom(32'h8c3bdf0e));
    rst        = 1'b1;
    bus_req    = '0;
    rom_data   = 8'h00;
    rom_ok     = 1'b0;
    main_latch = 8'hC3;   // sound command
    snd_on     = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    reset_outputs();
    rom_reads();
    psg_round_trip();
    channel_levels();
    filter_select();
    irq_handshake();
    timer_polling();
    $display("Simulation finished: PASS");
    $finish;
end

endmodule

// File: flist.f
+incdir+hdl
hdl/snd_bus_pkg.sv
hdl/snd_psg_pkg.sv
hdl/snd_bus_ctrl.sv
hdl/snd_timer.sv
hdl/snd_psg.sv
hdl/snd_ctrl_regs.sv
hdl/snd_board.sv
bench/snd_board_tb.sv
